/* eeprom_pkg.sv */
package eeprom_pkg;

    // 2K x 8 part, top three address bits ride in the device-select byte
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // fixed code of the serial EEPROM family
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // device-select byte, raw for the wire, fields for building and decoding
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] dev_code;
            logic [2:0] block;      // addr[10:8]
            logic       rw;         // 1 = read
        } f;
    } dev_select_t;

    // one shifter operation, one bit time for start and stop,
    // nine bit times for the byte operations
    typedef enum logic [2:0] {
        OP_START,
        OP_SEND,        // 8 bits out, ack sampled on the ninth
        OP_RECV_ACK,    // 8 bits in, ninth bit driven low
        OP_RECV_NACK,   // 8 bits in, ninth bit left high
        OP_STOP
    } shift_op_t;

endpackage

/* i2c_byte_shifter.sv */
`timescale 1ns/1ns
module i2c_byte_shifter import eeprom_pkg::*; #(
    parameter int QUARTER_CYCLES = 2
) (
    input  logic       CLK,
    input  logic       RESET,
    input  shift_op_t  op,
    input  logic [7:0] op_byte,
    input  logic       op_start,
    input  logic       sda_in,
    output logic       op_done,
    output logic       ack_seen,
    output logic [7:0] rx_byte,
    output logic       scl_oe,
    output logic       sda_oe
);

    localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

    logic            busy;
    shift_op_t       op_r;
    logic [QW-1:0]   q_cnt;
    logic [1:0]      phase;     // 0 scl low, 1-2 scl high, 3 scl low
    logic [3:0]      bit_cnt;
    logic [7:0]      sh_reg;
    logic            ack_r;
    logic            q_end;
    logic            last_bit;
    logic            recv;

    assign q_end    = (q_cnt == QW'(QUARTER_CYCLES - 1));
    assign last_bit = (op_r == OP_START) || (op_r == OP_STOP) || (bit_cnt == 4'd8);
    assign recv     = (op_r == OP_RECV_ACK) || (op_r == OP_RECV_NACK);

    // pin levels for one quarter, returns {scl_oe, sda_oe}
    function automatic logic [1:0] pin_levels(input shift_op_t o, input logic [1:0] ph,
                                              input logic [3:0] bn, input logic tx_bit);
        logic scl_low;
        logic sda_low;
        scl_low = (ph == 2'd0) || (ph == 2'd3);
        case (o)
            OP_START:
                sda_low = ph[1];            // falls while scl high
            OP_STOP:
            begin
                sda_low = !ph[1];           // rises while scl high
                if (ph == 2'd3)
                    scl_low = 1'b0;         // leave the bus idle
            end
            OP_SEND:
                sda_low = (bn < 4'd8) ? !tx_bit : 1'b0;
            OP_RECV_ACK:
                sda_low = (bn == 4'd8);
            default:
                sda_low = 1'b0;
        endcase
        return {scl_low, sda_low};
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            q_cnt   <= '0;
            phase   <= 2'd0;
            bit_cnt <= 4'd0;
            op_done <= 1'b0;
            scl_oe  <= 1'b0;
            sda_oe  <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (op_start)
            begin
                busy    <= 1'b1;
                q_cnt   <= '0;
                phase   <= 2'd0;
                bit_cnt <= 4'd0;
                {scl_oe, sda_oe} <= pin_levels(op, 2'd0, 4'd0, op_byte[7]);
            end
            else if (busy)
            begin
                if (!q_end)
                    q_cnt <= q_cnt + 1'b1;
                else
                begin
                    q_cnt <= '0;
                    if (phase != 2'd3)
                    begin
                        phase <= phase + 2'd1;
                        {scl_oe, sda_oe} <= pin_levels(op_r, phase + 2'd1, bit_cnt, sh_reg[7]);
                    end
                    else if (last_bit)
                    begin
                        busy    <= 1'b0;    // pins hold until the next op
                        op_done <= 1'b1;
                    end
                    else
                    begin
                        phase   <= 2'd0;
                        bit_cnt <= bit_cnt + 4'd1;
                        // sh_reg shifts on this edge, so the next bit is [6]
                        {scl_oe, sda_oe} <= pin_levels(op_r, 2'd0, bit_cnt + 4'd1, sh_reg[6]);
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (op_start)
        begin
            op_r   <= op;
            sh_reg <= op_byte;
        end
        else if (busy && q_end)
        begin
            if (phase == 2'd1 && recv && bit_cnt < 4'd8)
                sh_reg <= {sh_reg[6:0], sda_in};    // sample mid scl high
            if (phase == 2'd1 && op_r == OP_SEND && bit_cnt == 4'd8)
                ack_r <= !sda_in;
            if (phase == 2'd3 && op_r == OP_SEND)
                sh_reg <= {sh_reg[6:0], 1'b0};
        end
    end

    assign ack_seen = ack_r;
    assign rx_byte  = sh_reg;

    // controller must wait for op_done before the next op
    a_no_overlap: assert property (@(posedge CLK) disable iff (RESET)
        op_start |-> !busy);

endmodule

/* eeprom_ctrl.sv */
`timescale 1ns/1ns
module eeprom_ctrl import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req_wr,
    input  logic              req_rd,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic [DATA_W-1:0] req_wdata,
    input  logic              op_done,
    input  logic              ack_seen,
    input  logic [7:0]        rx_byte,
    output logic              done,
    output logic              done_nack,
    output logic [DATA_W-1:0] done_rdata,
    output shift_op_t         op,
    output logic [7:0]        op_byte,
    output logic              op_start
);

    localparam logic [3:0] S_IDLE    = 4'd0;
    localparam logic [3:0] S_START   = 4'd1;
    localparam logic [3:0] S_CTRL_W  = 4'd2;
    localparam logic [3:0] S_ADDR_LO = 4'd3;
    localparam logic [3:0] S_DATA_W  = 4'd4;
    localparam logic [3:0] S_RESTART = 4'd5;
    localparam logic [3:0] S_CTRL_R  = 4'd6;
    localparam logic [3:0] S_DATA_R  = 4'd7;
    localparam logic [3:0] S_STOP    = 4'd8;

    logic [3:0]  state;
    logic        wait_op;       // op issued, waiting for op_done
    logic        is_read;
    logic        nack_flag;     // sticky for the whole transaction
    dev_select_t dsel;

    always_comb
    begin
        dsel.f.dev_code = DEV_CODE;
        dsel.f.block    = req_addr[ADDR_W-1:8];
        dsel.f.rw       = (state == S_CTRL_R);
    end

    // every non-idle state issues exactly one shifter op
    assign op_start = (state != S_IDLE) && !wait_op;

    always_comb
    begin
        op      = OP_STOP;
        op_byte = 8'h00;
        case (state)
            S_START, S_RESTART:
                op = OP_START;
            S_CTRL_W, S_CTRL_R:
            begin
                op      = OP_SEND;
                op_byte = dsel.raw;
            end
            S_ADDR_LO:
            begin
                op      = OP_SEND;
                op_byte = req_addr[7:0];
            end
            S_DATA_W:
            begin
                op      = OP_SEND;
                op_byte = req_wdata;
            end
            S_DATA_R:
                op = OP_RECV_NACK;      // single byte read ends with nack
            default:
                op = OP_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            wait_op   <= 1'b0;
            is_read   <= 1'b0;
            nack_flag <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (op_start)
                wait_op <= 1'b1;
            if (state == S_IDLE)
            begin
                // skip the done cycle, the request is still up then
                if ((req_wr || req_rd) && !done)
                begin
                    state     <= S_START;
                    is_read   <= req_rd;
                    nack_flag <= 1'b0;
                end
            end
            else if (op_done)
            begin
                wait_op <= 1'b0;
                if (op == OP_SEND && !ack_seen)
                    nack_flag <= 1'b1;
                case (state)
                    S_START:
                        state <= S_CTRL_W;
                    S_CTRL_W:
                        state <= ack_seen ? S_ADDR_LO : S_STOP;
                    S_ADDR_LO:
                        if (!ack_seen)
                            state <= S_STOP;
                        else
                            state <= is_read ? S_RESTART : S_DATA_W;
                    S_DATA_W:
                        state <= S_STOP;
                    S_RESTART:
                        state <= S_CTRL_R;
                    S_CTRL_R:
                        state <= ack_seen ? S_DATA_R : S_STOP;
                    S_DATA_R:
                        state <= S_STOP;
                    default:
                    begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (op_done && state == S_DATA_R)
            done_rdata <= rx_byte;
        if (op_done && state == S_STOP)
            done_nack <= nack_flag;
    end

    a_rd_wr_excl: assert property (@(posedge CLK) disable iff (RESET)
        !(req_wr && req_rd));

    // arbiter keeps the request up for the whole transaction
    a_req_held: assert property (@(posedge CLK) disable iff (RESET)
        (state != S_IDLE) |-> (req_wr || req_rd));

endmodule

/* bus_arbiter.sv */
`timescale 1ns/1ns
module bus_arbiter import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr_0,
    input  logic              rd_0,
    input  logic [ADDR_W-1:0] addr_0,
    input  logic [DATA_W-1:0] wdata_0,
    output logic              ack_0,
    output logic              nack_0,
    output logic [DATA_W-1:0] rdata_0,
    input  logic              wr_1,
    input  logic              rd_1,
    input  logic [ADDR_W-1:0] addr_1,
    input  logic [DATA_W-1:0] wdata_1,
    output logic              ack_1,
    output logic              nack_1,
    output logic [DATA_W-1:0] rdata_1,
    output logic              req_wr,
    output logic              req_rd,
    output logic [ADDR_W-1:0] req_addr,
    output logic [DATA_W-1:0] req_wdata,
    input  logic              done,
    input  logic              done_nack,
    input  logic [DATA_W-1:0] done_rdata
);

    logic busy;
    logic grant;        // 1 = client 1 owns the controller
    logic last;         // client served most recently
    logic want_0;
    logic want_1;

    assign want_0 = wr_0 || rd_0;
    assign want_1 = wr_1 || rd_1;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy  <= 1'b0;
            grant <= 1'b0;
            last  <= 1'b1;      // client 0 wins the first tie
        end
        else if (!busy)
        begin
            if (want_0 || want_1)
            begin
                busy  <= 1'b1;
                grant <= (want_0 && want_1) ? !last : want_1;
            end
        end
        else if (done)
        begin
            busy <= 1'b0;
            last <= grant;
        end
    end

    assign req_wr    = busy && (grant ? wr_1 : wr_0);
    assign req_rd    = busy && (grant ? rd_1 : rd_0);
    assign req_addr  = grant ? addr_1 : addr_0;
    assign req_wdata = grant ? wdata_1 : wdata_0;

    assign ack_0   = done && busy && !grant;
    assign ack_1   = done && busy && grant;
    assign nack_0  = ack_0 && done_nack;
    assign nack_1  = ack_1 && done_nack;
    assign rdata_0 = done_rdata;
    assign rdata_1 = done_rdata;

    // granted client keeps its request up until its ack
    a_grant_held: assert property (@(posedge CLK) disable iff (RESET)
        busy |-> (grant ? want_1 : want_0));

endmodule

/* eeprom_subsys.sv */
`timescale 1ns/1ns
module eeprom_subsys import eeprom_pkg::*; #(
    parameter int QUARTER_CYCLES = 2
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr_0,
    input  logic              rd_0,
    input  logic [ADDR_W-1:0] addr_0,
    input  logic [DATA_W-1:0] wdata_0,
    output logic              ack_0,
    output logic              nack_0,
    output logic [DATA_W-1:0] rdata_0,
    input  logic              wr_1,
    input  logic              rd_1,
    input  logic [ADDR_W-1:0] addr_1,
    input  logic [DATA_W-1:0] wdata_1,
    output logic              ack_1,
    output logic              nack_1,
    output logic [DATA_W-1:0] rdata_1,
    inout  wire               scl,
    inout  wire               sda
);

    logic              req_wr;
    logic              req_rd;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              done;
    logic              done_nack;
    logic [DATA_W-1:0] done_rdata;
    shift_op_t         op;
    logic [7:0]        op_byte;
    logic              op_start;
    logic              op_done;
    logic              ack_seen;
    logic [7:0]        rx_byte;
    logic              scl_oe;
    logic              sda_oe;

    bus_arbiter u_arb (.*);

    eeprom_ctrl u_ctrl (.*);

    i2c_byte_shifter #(
        .QUARTER_CYCLES(QUARTER_CYCLES)
    ) u_shift (
        .CLK(CLK), .RESET(RESET),
        .op(op), .op_byte(op_byte), .op_start(op_start),
        .sda_in(sda),
        .op_done(op_done), .ack_seen(ack_seen), .rx_byte(rx_byte),
        .scl_oe(scl_oe), .sda_oe(sda_oe)
    );

    // open drain, pull-ups live outside
    assign scl = scl_oe ? 1'b0 : 1'bz;
    assign sda = sda_oe ? 1'b0 : 1'bz;

endmodule

/* eeprom_model.sv */
`timescale 1ns/1ns
module eeprom_model import eeprom_pkg::*; (
    input  logic present,
    inout  wire  scl,
    inout  wire  sda
);

    localparam int ST_DEV   = 0;
    localparam int ST_ADDR  = 1;
    localparam int ST_WDATA = 2;

    logic [7:0]  mem [0:2047];
    logic [7:0]  shreg;
    logic [7:0]  addr_lo;
    logic [2:0]  block;
    logic [3:0]  bit_cnt;
    logic        active = 1'b0;
    logic        tx_mode = 1'b0;
    logic        to_read = 1'b0;
    logic        sda_low = 1'b0;
    int          state;
    dev_select_t dsel;

    assign sda = sda_low ? 1'b0 : 1'bz;

    // power-on contents, every address bit shows up in the byte
    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i ^ (i >> 3));
    end

    always @(negedge sda)
    begin
        if (present && scl === 1'b1)    // start or repeated start
        begin
            active  = 1'b1;
            state   = ST_DEV;
            bit_cnt = 4'd0;
            tx_mode = 1'b0;
            to_read = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            active  = 1'b0;     // stop
            sda_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (bit_cnt < 4'd8 && !tx_mode)
                shreg = {shreg[6:0], sda === 1'b1};
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    always @(negedge scl)
    begin
        if (active && bit_cnt == 4'd8 && !tx_mode)
        begin
            sda_low = 1'b1;     // ack the byte
            case (state)
                ST_DEV:
                begin
                    dsel.raw = shreg;
                    if (dsel.f.dev_code == DEV_CODE)
                    begin
                        block   = dsel.f.block;
                        to_read = dsel.f.rw;
                        state   = ST_ADDR;
                    end
                    else
                    begin
                        sda_low = 1'b0;
                        active  = 1'b0;
                    end
                end
                ST_ADDR:
                begin
                    addr_lo = shreg;
                    state   = ST_WDATA;
                end
                default:
                    mem[{block, addr_lo}] = shreg;
            endcase
        end
        else if (active && bit_cnt == 4'd8)
            sda_low = 1'b0;     // master acks or nacks
        else if (active && bit_cnt == 4'd9)
        begin
            sda_low = 1'b0;
            bit_cnt = 4'd0;
            if (tx_mode)
                active = 1'b0;  // single byte reads only
            else if (to_read)
            begin
                tx_mode = 1'b1;
                shreg   = mem[{block, addr_lo}];
                sda_low = !shreg[7];
            end
        end
        else if (active && tx_mode && bit_cnt > 4'd0)
            sda_low = !shreg[7 - bit_cnt];
    end

endmodule

/* eeprom_checker.sv */
`timescale 1ns/1ns
module eeprom_checker import eeprom_pkg::*; #(
    parameter int MIN_ACK_GAP = 1
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              present,
    input  logic              report,
    input  logic              wr_0,
    input  logic              rd_0,
    input  logic [ADDR_W-1:0] addr_0,
    input  logic [DATA_W-1:0] wdata_0,
    input  logic              ack_0,
    input  logic              nack_0,
    input  logic [DATA_W-1:0] rdata_0,
    input  logic              wr_1,
    input  logic              rd_1,
    input  logic [ADDR_W-1:0] addr_1,
    input  logic [DATA_W-1:0] wdata_1,
    input  logic              ack_1,
    input  logic              nack_1,
    input  logic [DATA_W-1:0] rdata_1,
    input  wire               scl,
    input  wire               sda,
    output int                err_count
);

    logic [7:0] ref_mem [0:2047];
    int         acks [0:1];
    int         last_ack [0:1];  // cycle of each client's latest ack
    int         cyc = 0;
    int         served = -1;     // client of the last ack
    logic       other_held;      // other client requesting since then
    logic       bus_used = 1'b0;
    logic       reported = 1'b0;
    int         idle_errs = 0;

    initial
    begin
        err_count   = 0;
        acks[0]     = 0;
        acks[1]     = 0;
        last_ack[0] = -MIN_ACK_GAP;
        last_ack[1] = -MIN_ACK_GAP;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'(i ^ (i >> 3));     // same power-on fill as the part
    end

    task automatic check_ack(input int id, input logic wr, input logic [ADDR_W-1:0] addr,
                             input logic [7:0] wdata, input logic nack,
                             input logic [7:0] rdata);
        string name;
        int    errs;
        errs = 0;
        name = $sformatf("c%0d_%s_%0d", id, wr ? "write" : "read", acks[id]);
        acks[id]++;
        if (nack !== !present)
        begin
            $display("MISMATCH %s nack: expected %0b actual %0b", name, !present, nack);
            errs++;
        end
        else if (!nack && wr)
            ref_mem[addr] = wdata;
        else if (!nack && rdata !== ref_mem[addr])
        begin
            $display("MISMATCH %s rdata at %03h: expected %02h actual %02h",
                     name, addr, ref_mem[addr], rdata);
            errs++;
        end
        $display("%s addr %03h: %s", name, addr, (errs == 0) ? "ok" : "failed");
        err_count += errs;
    endtask

    always @(posedge CLK)
    begin
        if (!RESET)
        begin
            cyc++;
            if (!bus_used && (wr_0 || rd_0 || wr_1 || rd_1))
            begin
                bus_used = 1'b1;
                $display("idle_after_reset: %s", (idle_errs == 0) ? "ok" : "failed");
            end
            else if (!bus_used && (scl !== 1'b1 || sda !== 1'b1))
            begin
                $display("bus pulled low after reset with no request pending");
                idle_errs++;
                err_count++;
            end
            if (ack_0 && ack_1)
            begin
                $display("both clients acked in the same cycle");
                err_count++;
            end
            if (ack_0 && !(wr_0 || rd_0))
            begin
                $display("client 0 acked with no request pending");
                err_count++;
            end
            else if (ack_0)
                check_ack(0, wr_0, addr_0, wdata_0, nack_0, rdata_0);
            if (ack_1 && !(wr_1 || rd_1))
            begin
                $display("client 1 acked with no request pending");
                err_count++;
            end
            else if (ack_1)
                check_ack(1, wr_1, addr_1, wdata_1, nack_1, rdata_1);

            // acks to one client lie at least the shortest transaction apart
            for (int c = 0; c < 2; c++)
                if (c ? ack_1 : ack_0)
                begin
                    if (cyc - last_ack[c] < MIN_ACK_GAP)
                    begin
                        $display("client %0d acked again only %0d cycles after its last ack",
                                 c, cyc - last_ack[c]);
                        err_count++;
                    end
                    last_ack[c] = cyc;
                end

            // round robin, two acks in a row to one client only if the other let go
            if (ack_0 || ack_1)
            begin
                if (served == (ack_1 ? 1 : 0) && other_held)
                begin
                    $display("client %0d served twice while the other kept waiting", served);
                    err_count++;
                end
                served     = ack_1 ? 1 : 0;
                other_held = 1'b1;
            end
            else if (served >= 0)
                other_held = other_held && (served ? (wr_0 || rd_0) : (wr_1 || rd_1));

            if (report && !reported)
            begin
                reported = 1'b1;
                $display("checked %0d requests, %0d errors", acks[0] + acks[1], err_count);
            end
        end
    end

endmodule

/* tb_eeprom_subsys.sv */
`timescale 1ns/1ns
module tb_eeprom_subsys import eeprom_pkg::*; ();

    localparam int N_RAND = 30;     // per client, model present
    localparam int N_ABS  = 4;      // per client, model absent
    localparam int POOL   = 8;
    localparam int N_ALL  = N_RAND + N_ABS + POOL / 2;
    localparam int LIMIT  = 2 * N_ALL * 39 * 8 * 2 + 2000;

    logic              CLK;
    logic              RESET;
    logic              wr_0;
    logic              rd_0;
    logic [ADDR_W-1:0] addr_0;
    logic [DATA_W-1:0] wdata_0;
    logic              ack_0;
    logic              nack_0;
    logic [DATA_W-1:0] rdata_0;
    logic              wr_1;
    logic              rd_1;
    logic [ADDR_W-1:0] addr_1;
    logic [DATA_W-1:0] wdata_1;
    logic              ack_1;
    logic              nack_1;
    logic [DATA_W-1:0] rdata_1;
    wire               scl;
    wire               sda;
    logic              present;
    logic              report;
    int                err_count;
    integer            seed;
    int                cycles;

    logic [ADDR_W-1:0] pool [0:POOL-1];
    logic              st_wr [0:1][0:N_ALL-1];
    logic [ADDR_W-1:0] st_addr [0:1][0:N_ALL-1];
    logic [DATA_W-1:0] st_data [0:1][0:N_ALL-1];
    int                st_gap [0:1][0:N_ALL-1];

    pullup (scl);
    pullup (sda);

    eeprom_subsys #(.QUARTER_CYCLES(2)) u_dut (.*);
    eeprom_model u_mem (.*);
    eeprom_checker #(.MIN_ACK_GAP(11 * 8)) u_chk (.*);    // start, device byte, stop

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic drive(input int id, input logic wr, input logic rd,
                         input logic [ADDR_W-1:0] addr, input logic [7:0] data);
        if (id == 0)
        begin
            wr_0    <= wr;
            rd_0    <= rd;
            addr_0  <= addr;
            wdata_0 <= data;
        end
        else
        begin
            wr_1    <= wr;
            rd_1    <= rd;
            addr_1  <= addr;
            wdata_1 <= data;
        end
    endtask

    // called on a rising edge, next request goes up right at the ack edge
    task automatic run_client(input int id, input int first, input int last);
        for (int k = first; k < last; k++)
        begin
            drive(id, st_wr[id][k], !st_wr[id][k], st_addr[id][k], st_data[id][k]);
            do
                @(posedge CLK);
            while (!(id ? ack_1 : ack_0));
            if (st_gap[id][k] > 0 || k == last - 1)
            begin
                drive(id, 1'b0, 1'b0, st_addr[id][k], st_data[id][k]);
                repeat (st_gap[id][k]) @(posedge CLK);
            end
        end
    endtask

    initial
    begin
        RESET = 1'b1;
        present = 1'b1;
        report = 1'b0;
        drive(0, 1'b0, 1'b0, '0, '0);
        drive(1, 1'b0, 1'b0, '0, '0);
        seed = 71212;
        for (int i = 0; i < POOL; i++)
            pool[i] = ADDR_W'($random(seed));
        for (int c = 0; c < 2; c++)
            for (int k = 0; k < N_ALL; k++)
            begin
                st_data[c][k] = 8'($random(seed));
                st_gap[c][k]  = ($random(seed) % 4 == 0) ? 3 : 0;
                if (k < N_RAND + N_ABS)
                begin
                    st_wr[c][k]   = $random(seed) & 1;
                    st_addr[c][k] = pool[$unsigned($random(seed)) % POOL];
                end
                else
                begin
                    st_wr[c][k]   = 1'b0;   // read back the whole pool
                    st_addr[c][k] = pool[(k - N_RAND - N_ABS) * 2 + c];
                end
            end
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;
        repeat (40) @(posedge CLK);     // quiet bus
        fork
            run_client(0, 0, N_RAND);
            run_client(1, 0, N_RAND);
        join
        repeat (2) @(posedge CLK);
        present <= 1'b0;
        fork
            run_client(0, N_RAND, N_RAND + N_ABS);
            run_client(1, N_RAND, N_RAND + N_ABS);
        join
        repeat (2) @(posedge CLK);
        present <= 1'b1;
        fork
            run_client(0, N_RAND + N_ABS, N_ALL);
            run_client(1, N_RAND + N_ABS, N_ALL);
        join
        repeat (4) @(posedge CLK);
        report <= 1'b1;
        repeat (2) @(posedge CLK);
        if (err_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < LIMIT)
        begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: requests still unacknowledged after %0d cycles", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* files.f */
eeprom_pkg.sv
i2c_byte_shifter.sv
eeprom_ctrl.sv
bus_arbiter.sv
eeprom_subsys.sv
eeprom_model.sv
eeprom_checker.sv
tb_eeprom_subsys.sv
